//--- filelist.f
rv_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_mem_wb.sv
rv_hazard_unit.sv
rv_core.sv
rv_core_sva.sv
tb_rv_core.sv

//--- Makefile
TOP = tb_rv_core

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int N_STORES      = 11;
    localparam int STORE_TIMEOUT = 300;
    localparam int IDLE_CYCLES   = 60;

    logic        clk;
    logic        rst_n;
    logic [31:0] idt;
    logic        acki_n;
    logic [31:0] drdata;
    logic        ackd_n;
    logic [31:0] iad;
    logic [31:0] dad;
    logic [31:0] dwdata;
    logic        mreq;
    logic        write;

    logic [31:0] rom [0:63];
    logic [31:0] ram [0:63];
    logic [31:0] exp_addr [0:N_STORES-1];
    logic [31:0] exp_data [0:N_STORES-1];
    integer      seed;
    int          i_busy;
    int          d_busy;
    int          errors;
    int          timeouts;
    logic        store_seen;
    logic [31:0] seen_addr;
    logic [31:0] seen_data;

    rv_core i_dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_idt    (idt),
        .i_acki_n (acki_n),
        .i_drdata (drdata),
        .i_ackd_n (ackd_n),
        .o_iad    (iad),
        .o_dad    (dad),
        .o_dwdata (dwdata),
        .o_mreq   (mreq),
        .o_write  (write)
    );

    bind rv_core rv_core_sva i_sva (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ackd_n (i_ackd_n),
        .i_mreq   (o_mreq),
        .i_write  (o_write),
        .i_dad    (o_dad),
        .i_dwdata (o_dwdata)
    );

    always #50 clk = ~clk;

    // RV32I instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Busy stretch of 0 to 3 cycles, often none
    function automatic int stretch_next(input int busy);
        int pick;
        if (busy != 0) begin
            return busy - 1;
        end
        pick = $random(seed) & 7;
        return (pick > 3) ? 0 : pick;
    endfunction

    task automatic expect_store(input int k, input logic [31:0] addr, input logic [31:0] data);
        exp_addr[k] = addr;
        exp_data[k] = data;
    endtask

    task automatic load_program();
        for (int a = 0; a < 64; a++) begin
            rom[a] = 32'h0000_0013;
            ram[a] = 32'h5ca1_0000 ^ 32'(a * 4);
        end
        rom[0]  = i_type(12'hffd, 5'd0, 3'b000, 5'd1, 7'b0010011);
        rom[1]  = i_type(12'd6, 5'd0, 3'b000, 5'd2, 7'b0010011);
        rom[2]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
        rom[3]  = r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4);
        rom[4]  = s_type(12'd0, 5'd3, 5'd0);
        rom[5]  = s_type(12'd4, 5'd4, 5'd0);
        rom[6]  = r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);
        rom[7]  = r_type(7'h00, 5'd4, 5'd5, 3'b110, 5'd6);
        rom[8]  = r_type(7'h00, 5'd2, 5'd6, 3'b100, 5'd7);
        rom[9]  = r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8);
        rom[10] = s_type(12'd8, 5'd7, 5'd0);
        rom[11] = r_type(7'h20, 5'd8, 5'd1, 3'b101, 5'd9);
        rom[12] = r_type(7'h00, 5'd8, 5'd1, 3'b101, 5'd10);
        rom[13] = r_type(7'h00, 5'd8, 5'd2, 3'b001, 5'd11);
        rom[14] = {20'h12345, 5'd12, 7'b0110111};
        rom[15] = s_type(12'd12, 5'd9, 5'd0);
        rom[16] = s_type(12'd16, 5'd10, 5'd0);
        rom[17] = s_type(12'd20, 5'd11, 5'd0);
        rom[18] = s_type(12'd24, 5'd12, 5'd0);
        // Load then dependent add
        rom[19] = i_type(12'd0, 5'd0, 3'b010, 5'd13, 7'b0000011);
        rom[20] = r_type(7'h00, 5'd11, 5'd13, 3'b000, 5'd14);
        rom[21] = s_type(12'd28, 5'd14, 5'd0);
        rom[22] = i_type(12'h100, 5'd14, 3'b110, 5'd15, 7'b0010011);
        rom[23] = i_type(12'd4, 5'd15, 3'b001, 5'd16, 7'b0010011);
        rom[24] = s_type(12'd32, 5'd16, 5'd0);
        // Taken beq and bne, each with two stores that must be squashed
        rom[25] = b_type(13'd12, 5'd13, 5'd3, 3'b000);
        rom[26] = s_type(12'd40, 5'd0, 5'd0);
        rom[27] = s_type(12'd44, 5'd0, 5'd0);
        rom[28] = b_type(13'd12, 5'd4, 5'd3, 3'b001);
        rom[29] = s_type(12'd48, 5'd0, 5'd0);
        rom[30] = s_type(12'd52, 5'd0, 5'd0);
        rom[31] = b_type(13'd8, 5'd4, 5'd3, 3'b000);
        rom[32] = s_type(12'd36, 5'd4, 5'd0);
        rom[33] = j_type(21'd12, 5'd17);
        rom[34] = s_type(12'd56, 5'd0, 5'd0);
        rom[35] = s_type(12'd60, 5'd0, 5'd0);
        rom[36] = s_type(12'd64, 5'd17, 5'd0);
        rom[37] = j_type(21'd0, 5'd0);
    endtask

    task automatic load_expected();
        expect_store(0, 32'd0, 32'd3);
        expect_store(1, 32'd4, 32'd9);
        expect_store(2, 32'd8, 32'd11);
        expect_store(3, 32'd12, 32'hffff_fffe);
        expect_store(4, 32'd16, 32'h7fff_fffe);
        expect_store(5, 32'd20, 32'd12);
        expect_store(6, 32'd24, 32'h1234_5000);
        expect_store(7, 32'd28, 32'd15);
        expect_store(8, 32'd32, 32'h0000_10f0);
        expect_store(9, 32'd36, 32'd9);
        expect_store(10, 32'd64, 32'd136);
    endtask

    // One clock: drive memories on the falling edge and note a completed store
    task automatic run_cycle();
        @(negedge clk);
        acki_n = (i_busy != 0);
        ackd_n = (d_busy != 0);
        i_busy = stretch_next(i_busy);
        d_busy = stretch_next(d_busy);
        idt    = rom[iad[7:2]];
        drdata = ram[dad[7:2]];
        store_seen = mreq && write && !acki_n && !ackd_n;
        if (store_seen) begin
            seen_addr = dad;
            seen_data = dwdata;
            ram[dad[7:2]] = dwdata;
        end
    endtask

    task automatic wait_store(input int k);
        int t;
        t = 0;
        do begin
            run_cycle();
            t++;
        end while (!store_seen && t < STORE_TIMEOUT);
        if (!store_seen) begin
            $display("Timed out waiting for store %0d to address %h", k, exp_addr[k]);
            timeouts++;
        end else if (seen_addr != exp_addr[k] || seen_data != exp_data[k]) begin
            $display("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h", $time, k,
                     seen_data, seen_addr, exp_data[k], exp_addr[k]);
            errors++;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        idt        = 32'h0000_0013;
        acki_n     = 1'b0;
        ackd_n     = 1'b0;
        drdata     = '0;
        seed       = 32'h40f2_c4e9;
        i_busy     = 0;
        d_busy     = 0;
        errors     = 0;
        timeouts   = 0;
        store_seen = 1'b0;
        seen_addr  = '0;
        seen_data  = '0;
        load_program();
        load_expected();

        repeat (8) run_cycle();
        if (mreq || write || iad != rv_pkg::RESET_PC) begin
            $display("FAILED at %0t: reset state mreq=%b write=%b iad=%h", $time, mreq, write,
                     iad);
            errors++;
        end
        rst_n = 1'b1;

        for (int k = 0; k < N_STORES && timeouts == 0; k++) begin
            wait_store(k);
        end

        // Nothing more may be stored once the program spins
        for (int t = 0; t < IDLE_CYCLES && timeouts == 0; t++) begin
            run_cycle();
            if (store_seen) begin
                $display("FAILED at %0t: unexpected store of %h to %h", $time, seen_data,
                         seen_addr);
                errors++;
            end
        end

        $display("Store checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        i_ackd_n,
    input logic        i_mreq,
    input logic        i_write,
    input logic [31:0] i_dad,
    input logic [31:0] i_dwdata
);

    write_needs_req: assert property (@(posedge i_clk) i_write |-> i_mreq)
        else $error("write strobe without a request");

    no_req_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_mreq)
        else $error("data request during reset");

    dad_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_mreq |-> (i_dad[1:0] == 2'b00))
        else $error("data address not word aligned");

    // Request held until the data acknowledge drops
    req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_mreq && i_ackd_n) |=> (i_mreq && $stable(i_write) && $stable(i_dad)
                                  && $stable(i_dwdata)))
        else $error("data request changed while acknowledge was high");

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [rv_pkg::XLEN-1:0] i_idt,
    input  logic                    i_acki_n,
    input  logic [rv_pkg::XLEN-1:0] i_drdata,
    input  logic                    i_ackd_n,
    output logic [rv_pkg::XLEN-1:0] o_iad,
    output logic [rv_pkg::XLEN-1:0] o_dad,
    output logic [rv_pkg::XLEN-1:0] o_dwdata,
    output logic                    o_mreq,
    output logic                    o_write
);
    import rv_pkg::*;

    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    mem_wb_t         wb;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            rs1_used;
    logic            rs2_used;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] ex_fwd;
    logic [XLEN-1:0] mem_fwd;
    logic [XLEN-1:0] target;
    logic            redirect;
    logic            stall;
    logic            flush;
    logic            freeze;

    rv_fetch u_fetch (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_idt      (i_idt),
        .i_stall    (stall),
        .i_flush    (flush),
        .i_freeze   (freeze),
        .i_redirect (redirect),
        .i_target   (target),
        .o_iad      (o_iad),
        .o_if_id    (if_id)
    );

    rv_decode u_decode (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_if_id    (if_id),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .i_ex_fwd   (ex_fwd),
        .i_mem_fwd  (mem_fwd),
        .i_fwd_a    (fwd_a),
        .i_fwd_b    (fwd_b),
        .i_stall    (stall),
        .i_flush    (flush),
        .i_freeze   (freeze),
        .o_rs1      (rs1),
        .o_rs2      (rs2),
        .o_rs1_used (rs1_used),
        .o_rs2_used (rs2_used),
        .o_id_ex    (id_ex)
    );

    rv_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_wb       (wb),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    rv_execute u_execute (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_id_ex    (id_ex),
        .i_freeze   (freeze),
        .o_ex_fwd   (ex_fwd),
        .o_redirect (redirect),
        .o_target   (target),
        .o_ex_mem   (ex_mem)
    );

    rv_mem_wb u_mem_wb (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_ex_mem  (ex_mem),
        .i_drdata  (i_drdata),
        .i_freeze  (freeze),
        .o_dad     (o_dad),
        .o_dwdata  (o_dwdata),
        .o_mreq    (o_mreq),
        .o_write   (o_write),
        .o_mem_fwd (mem_fwd),
        .o_wb      (wb)
    );

    rv_hazard_unit u_hazard (
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_rs1_used (rs1_used),
        .i_rs2_used (rs2_used),
        .i_id_ex    (id_ex),
        .i_ex_mem   (ex_mem),
        .i_redirect (redirect),
        .i_acki_n   (i_acki_n),
        .i_ackd_n   (i_ackd_n),
        .i_mreq     (o_mreq),
        .o_fwd_a    (fwd_a),
        .o_fwd_b    (fwd_b),
        .o_stall    (stall),
        .o_flush    (flush),
        .o_freeze   (freeze)
    );

endmodule

`default_nettype wire

//--- rv_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit (
    input  logic [4:0]       i_rs1,
    input  logic [4:0]       i_rs2,
    input  logic             i_rs1_used,
    input  logic             i_rs2_used,
    input  rv_pkg::id_ex_t   i_id_ex,
    input  rv_pkg::ex_mem_t  i_ex_mem,
    input  logic             i_redirect,
    input  logic             i_acki_n,
    input  logic             i_ackd_n,
    input  logic             i_mreq,
    output rv_pkg::fwd_sel_e o_fwd_a,
    output rv_pkg::fwd_sel_e o_fwd_b,
    output logic             o_stall,
    output logic             o_flush,
    output logic             o_freeze
);
    import rv_pkg::*;

    logic ex_writes;
    logic mem_writes;
    logic load_in_ex;

    assign ex_writes  = i_id_ex.valid && i_id_ex.ctrl.reg_write && (i_id_ex.rd != 5'd0);
    assign mem_writes = i_ex_mem.valid && i_ex_mem.ctrl.reg_write && (i_ex_mem.rd != 5'd0);
    assign load_in_ex = ex_writes && i_id_ex.ctrl.mem_read;

    // Youngest producer wins
    function automatic fwd_sel_e fwd_for(input logic [4:0] rs);
        if (ex_writes && i_id_ex.rd == rs) begin
            return FWD_EX;
        end else if (mem_writes && i_ex_mem.rd == rs) begin
            return FWD_MEM;
        end
        return FWD_RF;
    endfunction

    always_comb begin
        o_fwd_a = fwd_for(i_rs1);
        o_fwd_b = fwd_for(i_rs2);
    end

    // Load data arrives one stage too late for EX forwarding
    assign o_stall = load_in_ex
        && ((i_rs1_used && i_id_ex.rd == i_rs1) || (i_rs2_used && i_id_ex.rd == i_rs2));

    assign o_flush  = i_redirect;
    assign o_freeze = i_acki_n || (i_ackd_n && i_mreq);

endmodule

`default_nettype wire

//--- rv_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_mem_wb (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  rv_pkg::ex_mem_t         i_ex_mem,
    input  logic [rv_pkg::XLEN-1:0] i_drdata,
    input  logic                    i_freeze,
    output logic [rv_pkg::XLEN-1:0] o_dad,
    output logic [rv_pkg::XLEN-1:0] o_dwdata,
    output logic                    o_mreq,
    output logic                    o_write,
    output logic [rv_pkg::XLEN-1:0] o_mem_fwd,
    output rv_pkg::mem_wb_t         o_wb
);
    import rv_pkg::*;

    logic is_load;
    logic is_store;

    assign is_load  = i_ex_mem.valid && i_ex_mem.ctrl.mem_read;
    assign is_store = i_ex_mem.valid && i_ex_mem.ctrl.mem_write;

    // Data bus strobes, held by freeze until the acknowledge drops
    assign o_mreq   = is_load || is_store;
    assign o_write  = is_store;
    assign o_dad    = i_ex_mem.result;
    assign o_dwdata = i_ex_mem.store_data;

    // Load data only valid once i_ackd_n is low
    assign o_mem_fwd = is_load ? i_drdata : i_ex_mem.result;

    // MEM/WB register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb <= '0;
        end else if (!i_freeze) begin
            o_wb.valid     <= i_ex_mem.valid;
            o_wb.wdata     <= o_mem_fwd;
            o_wb.rd        <= i_ex_mem.rd;
            o_wb.reg_write <= i_ex_mem.valid && i_ex_mem.ctrl.reg_write;
        end
    end

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  rv_pkg::id_ex_t          i_id_ex,
    input  logic                    i_freeze,
    output logic [rv_pkg::XLEN-1:0] o_ex_fwd,
    output logic                    o_redirect,
    output logic [rv_pkg::XLEN-1:0] o_target,
    output rv_pkg::ex_mem_t         o_ex_mem
);
    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_plus4;
    logic [4:0]      shamt;
    logic            equal;
    logic            taken;

    assign op_a  = i_id_ex.rs1_val;
    assign op_b  = i_id_ex.ctrl.use_imm ? i_id_ex.imm : i_id_ex.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL: alu_res = op_a << shamt;
            ALU_SRL: alu_res = op_a >> shamt;
            ALU_SRA: alu_res = $signed(op_a) >>> shamt;
            ALU_LUI: alu_res = op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    // Link value for jal
    assign pc_plus4 = i_id_ex.pc + XLEN'(4);
    assign o_ex_fwd = i_id_ex.ctrl.jump ? pc_plus4 : alu_res;

    // Branches compare the raw rs2 operand, not the immediate
    assign equal      = (i_id_ex.rs1_val == i_id_ex.rs2_val);
    assign taken      = i_id_ex.ctrl.branch && (i_id_ex.ctrl.branch_ne ? !equal : equal);
    assign o_redirect = i_id_ex.valid && (i_id_ex.ctrl.jump || taken);
    assign o_target   = i_id_ex.pc + i_id_ex.imm;

    // EX/MEM register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem <= '0;
        end else if (!i_freeze) begin
            o_ex_mem.valid      <= i_id_ex.valid;
            o_ex_mem.result     <= o_ex_fwd;
            o_ex_mem.store_data <= i_id_ex.rs2_val;
            o_ex_mem.rd         <= i_id_ex.rd;
            o_ex_mem.ctrl       <= i_id_ex.ctrl;
        end
    end

endmodule

`default_nettype wire

//--- rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  rv_pkg::if_id_t          i_if_id,
    input  logic [rv_pkg::XLEN-1:0] i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0] i_rs2_data,
    input  logic [rv_pkg::XLEN-1:0] i_ex_fwd,
    input  logic [rv_pkg::XLEN-1:0] i_mem_fwd,
    input  rv_pkg::fwd_sel_e        i_fwd_a,
    input  rv_pkg::fwd_sel_e        i_fwd_b,
    input  logic                    i_stall,
    input  logic                    i_flush,
    input  logic                    i_freeze,
    output logic [4:0]              o_rs1,
    output logic [4:0]              o_rs2,
    output logic                    o_rs1_used,
    output logic                    o_rs2_used,
    output rv_pkg::id_ex_t          o_id_ex
);
    import rv_pkg::*;

    logic [XLEN-1:0] instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            legal;
    logic            decode_ok;
    logic            issue;
    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;

    function automatic logic [XLEN-1:0] fwd_pick(input fwd_sel_e sel,
                                                 input logic [XLEN-1:0] rf_val);
        case (sel)
            FWD_EX:  return i_ex_fwd;
            FWD_MEM: return i_mem_fwd;
            default: return rf_val;
        endcase
    endfunction

    assign instr  = i_if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign o_rs1  = instr[19:15];
    assign o_rs2  = instr[24:20];

    always_comb begin
        ctrl  = '0;
        legal = 1'b1;
        imm   = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            OP_REG, OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = (opcode == OP_IMM);
                case (funct3)
                    3'b000:  ctrl.alu_op = (opcode == OP_REG && instr[30]) ? ALU_SUB : ALU_ADD;
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b101:  ctrl.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = ALU_LUI;
                imm            = {instr[31:12], 12'b0};
            end
            OP_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                // only beq and bne
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                legal          = (funct3[2:1] == 2'b00);
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: legal = 1'b0;
        endcase
    end

    assign decode_ok  = i_if_id.valid && legal;
    assign o_rs1_used = decode_ok && (opcode != OP_LUI) && (opcode != OP_JAL);
    assign o_rs2_used = decode_ok && (opcode inside {OP_REG, OP_STORE, OP_BRANCH});
    assign issue      = decode_ok && !i_stall && !i_flush;

    always_comb begin
        op_a = fwd_pick(i_fwd_a, i_rs1_data);
        op_b = fwd_pick(i_fwd_b, i_rs2_data);
    end

    // ID/EX register, bubble on stall or flush
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= '0;
        end else if (!i_freeze) begin
            o_id_ex.valid   <= issue;
            o_id_ex.pc      <= i_if_id.pc;
            o_id_ex.rs1_val <= op_a;
            o_id_ex.rs2_val <= op_b;
            o_id_ex.imm     <= imm;
            o_id_ex.rd      <= instr[11:7];
            o_id_ex.ctrl    <= issue ? ctrl : '0;
        end
    end

endmodule

`default_nettype wire

//--- rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [rv_pkg::XLEN-1:0] i_idt,
    input  logic                    i_stall,
    input  logic                    i_flush,
    input  logic                    i_freeze,
    input  logic                    i_redirect,
    input  logic [rv_pkg::XLEN-1:0] i_target,
    output logic [rv_pkg::XLEN-1:0] o_iad,
    output rv_pkg::if_id_t          o_if_id
);
    import rv_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;

    // Redirect wins, a load-use stall keeps the same address
    always_comb begin
        if (i_redirect) begin
            pc_next = i_target;
        end else if (i_stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + XLEN'(4);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= RESET_PC;
        end else if (!i_freeze) begin
            pc <= pc_next;
        end
    end

    assign o_iad = pc;

    // IF/ID register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_if_id <= '0;
        end else if (!i_freeze) begin
            if (i_flush) begin
                o_if_id.valid <= 1'b0;
            end else if (!i_stall) begin
                o_if_id <= '{valid: 1'b1, pc: pc, instr: i_idt};
            end
        end
    end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic [4:0]              i_rs1,
    input  logic [4:0]              i_rs2,
    input  rv_pkg::mem_wb_t         i_wb,
    output logic [rv_pkg::XLEN-1:0] o_rs1_data,
    output logic [rv_pkg::XLEN-1:0] o_rs2_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];
    logic            wr_en;

    assign wr_en = i_wb.valid && i_wb.reg_write && (i_wb.rd != 5'd0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.rd] <= i_wb.wdata;
        end
    end

    // x0 reads zero, a same-cycle write is passed through
    function automatic logic [XLEN-1:0] rd_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (wr_en && addr == i_wb.rd) begin
            return i_wb.wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rs1_data = rd_port(i_rs1);
        o_rs2_data = rd_port(i_rs2);
    end

endmodule

`default_nettype wire

//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // Operand source picked in decode
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM
    } fwd_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        logic    use_imm;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        logic [4:0]      rd;
        ctrl_t           ctrl;
    } id_ex_t;

    // Result is already pc+4 for jal
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
        ctrl_t           ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] wdata;
        logic [4:0]      rd;
        logic            reg_write;
    } mem_wb_t;

endpackage

`default_nettype wire
